/* common/z80_defs.svh */
`ifndef Z80_DEFS_SVH
`define Z80_DEFS_SVH

`define Z80_ADDR_W 16
`define Z80_DATA_W 8
`define Z80_INSN_W 24
`define Z80_MAX_LEN 3

// 3-bit register field codes
// Code 6 selects (HL) and names no register
`define Z80_REG_B 3'd0
`define Z80_REG_C 3'd1
`define Z80_REG_D 3'd2
`define Z80_REG_E 3'd3
`define Z80_REG_H 3'd4
`define Z80_REG_L 3'd5
`define Z80_REG_A 3'd7

// Opcodes with no register field
`define Z80_OP_LD_IND_BC_A 8'h02
`define Z80_OP_LD_A_IND_BC 8'h0A
`define Z80_OP_LD_IND_DE_A 8'h12
`define Z80_OP_LD_A_IND_DE 8'h1A
`define Z80_OP_LD_IND_NN_HL 8'h22
`define Z80_OP_LD_HL_IND_NN 8'h2A
`define Z80_OP_LD_IND_NN_A 8'h32
`define Z80_OP_LD_IND_HL_N 8'h36
`define Z80_OP_LD_A_IND_NN 8'h3A

`endif

/* common/z80_pkg.sv */
`include "z80_defs.svh"

package z80_pkg;

    typedef logic [`Z80_ADDR_W-1:0] addr_t;
    typedef logic [`Z80_DATA_W-1:0] byte_t;
    typedef logic [2*`Z80_DATA_W-1:0] word_t;

    // Little-endian, opcode byte in bits 7:0
    typedef logic [`Z80_INSN_W-1:0] insn_t;

    typedef logic [2:0] reg8_t;
    typedef logic [1:0] pair_t;
    typedef logic [1:0] insn_len_t;

    typedef enum logic [3:0] {
        GRP_NOP,
        GRP_LD_R_R,
        GRP_LD_R_N,
        GRP_LD_DD_NN,
        GRP_LD_A_IND_NN,
        GRP_LD_IND_NN_A,
        GRP_LD_A_IND_BCDE,
        GRP_LD_IND_BCDE_A,
        GRP_LD_IND_HL_R,
        GRP_LD_IND_HL_N,
        GRP_LD_HL_IND_NN,
        GRP_LD_IND_NN_HL,
        GRP_NEED_MORE,
        GRP_NOP_OTHER
    } insn_group_t;

    // Low half mirrors the 3-bit field codes, upper half holds the pairs in dd order
    typedef enum logic [3:0] {
        SEL_B  = {1'b0, `Z80_REG_B},
        SEL_C  = {1'b0, `Z80_REG_C},
        SEL_D  = {1'b0, `Z80_REG_D},
        SEL_E  = {1'b0, `Z80_REG_E},
        SEL_H  = {1'b0, `Z80_REG_H},
        SEL_L  = {1'b0, `Z80_REG_L},
        SEL_A  = {1'b0, `Z80_REG_A},
        SEL_BC = 4'd8,
        SEL_DE = 4'd9,
        SEL_HL = 4'd10,
        SEL_SP = 4'd11
    } reg_sel_t;

    function automatic reg_sel_t sel_reg8(reg8_t code);
        return reg_sel_t'({1'b0, code});
    endfunction

    function automatic reg_sel_t sel_pair(pair_t code);
        return reg_sel_t'({2'b10, code});
    endfunction

endpackage

/* fetch/insn_decoder.sv */
`include "z80_defs.svh"

module insn_decoder (
    input  z80_pkg::insn_t       insn,
    input  z80_pkg::insn_len_t   byte_count,
    output z80_pkg::insn_group_t group,
    output z80_pkg::insn_len_t   length
);
    import z80_pkg::*;

    byte_t       op;
    insn_group_t op_group;

    assign op = insn[7:0];

    // Unprefixed opcodes are fully decided by the first byte
    always_comb begin
        op_group = GRP_NOP_OTHER;
        length   = 2'd1;
        case (op[7:6])
            2'b00: begin
                if (op == 8'h00) begin
                    op_group = GRP_NOP;
                end else if (op == `Z80_OP_LD_IND_HL_N) begin
                    op_group = GRP_LD_IND_HL_N;
                    length   = 2'd2;
                end else if (op[2:0] == 3'd6) begin
                    op_group = GRP_LD_R_N;
                    length   = 2'd2;
                end else if (op[3:0] == 4'h1) begin
                    op_group = GRP_LD_DD_NN;
                    length   = 2'd3;
                end else begin
                    case (op)
                        `Z80_OP_LD_IND_BC_A,
                        `Z80_OP_LD_IND_DE_A:  op_group = GRP_LD_IND_BCDE_A;
                        `Z80_OP_LD_A_IND_BC,
                        `Z80_OP_LD_A_IND_DE:  op_group = GRP_LD_A_IND_BCDE;
                        `Z80_OP_LD_IND_NN_HL: op_group = GRP_LD_IND_NN_HL;
                        `Z80_OP_LD_HL_IND_NN: op_group = GRP_LD_HL_IND_NN;
                        `Z80_OP_LD_IND_NN_A:  op_group = GRP_LD_IND_NN_A;
                        `Z80_OP_LD_A_IND_NN:  op_group = GRP_LD_A_IND_NN;
                        default:              op_group = GRP_NOP_OTHER;
                    endcase
                    if (op_group != GRP_NOP_OTHER && op[5]) begin
                        length = 2'd3;
                    end
                end
            end
            2'b01: begin
                // LD r,(HL) and HALT fall through as one-byte no-ops
                if (op[2:0] == 3'd6) begin
                    op_group = GRP_NOP_OTHER;
                end else if (op[5:3] == 3'd6) begin
                    op_group = GRP_LD_IND_HL_R;
                end else begin
                    op_group = GRP_LD_R_R;
                end
            end
            default: op_group = GRP_NOP_OTHER;
        endcase
    end

    assign group = (byte_count < length) ? GRP_NEED_MORE : op_group;

endmodule

/* fetch/insn_collector.sv */
`include "z80_defs.svh"

module insn_collector (
    input  logic                 clk,
    input  logic                 reset,
    input  z80_pkg::byte_t       mem_data,
    input  logic                 insn_done,
    output z80_pkg::addr_t       fetch_addr,
    output z80_pkg::insn_t       insn,
    output z80_pkg::insn_len_t   insn_len,
    output z80_pkg::insn_group_t group,
    output z80_pkg::word_t       operand,
    output logic                 insn_ready
);
    import z80_pkg::*;

    insn_t     coll_bytes;
    insn_len_t coll_count;
    logic      held;
    addr_t     pc;

    insn_t     merged;
    insn_len_t byte_count;

    // While fetching, the byte on the bus joins the collected ones this cycle
    always_comb begin
        merged = coll_bytes;
        if (!held && coll_count < `Z80_MAX_LEN) begin
            merged[coll_count*`Z80_DATA_W +: `Z80_DATA_W] = mem_data;
        end
    end

    assign byte_count = held ? coll_count : coll_count + 2'd1;

    insn_decoder decoder (
        .insn       (merged),
        .byte_count (byte_count),
        .group      (group),
        .length     (insn_len)
    );

    assign insn_ready = (group != GRP_NEED_MORE) && (insn_len == byte_count);
    assign insn       = merged;
    assign operand    = merged[`Z80_INSN_W-1:`Z80_DATA_W];

    // pc is the address on the bus while fetching
    // fetch_addr is the byte that comes after it
    assign fetch_addr = held ? pc : pc + 16'd1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc         <= '0;
            coll_count <= '0;
            held       <= 1'b0;
        end else begin
            pc <= fetch_addr;
            if (insn_done) begin
                coll_count <= '0;
                held       <= 1'b0;
            end else if (!held) begin
                coll_count <= byte_count;
                held       <= insn_ready;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (insn_done) begin
            coll_bytes <= '0;
        end else if (!held) begin
            coll_bytes <= merged;
        end
    end

endmodule

/* hdl/register_file.sv */
module register_file (
    input  logic              clk,
    input  logic              reset,
    input  z80_pkg::reg_sel_t rd1_sel,
    output z80_pkg::word_t    rd1_data,
    input  z80_pkg::reg_sel_t rd2_sel,
    output z80_pkg::word_t    rd2_data,
    input  logic              wr_en,
    input  z80_pkg::reg_sel_t wr_sel,
    input  z80_pkg::word_t    wr_data
);
    import z80_pkg::*;

    byte_t reg_b, reg_c, reg_d, reg_e, reg_h, reg_l, reg_a;
    word_t reg_sp;
    word_t view [16];

    // Every selector code as one 16-bit value, unused codes read zero
    always_comb begin
        view         = '{default: '0};
        view[SEL_B]  = word_t'(reg_b);
        view[SEL_C]  = word_t'(reg_c);
        view[SEL_D]  = word_t'(reg_d);
        view[SEL_E]  = word_t'(reg_e);
        view[SEL_H]  = word_t'(reg_h);
        view[SEL_L]  = word_t'(reg_l);
        view[SEL_A]  = word_t'(reg_a);
        view[SEL_BC] = {reg_b, reg_c};
        view[SEL_DE] = {reg_d, reg_e};
        view[SEL_HL] = {reg_h, reg_l};
        view[SEL_SP] = reg_sp;
    end

    assign rd1_data = view[rd1_sel];
    assign rd2_data = view[rd2_sel];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_b  <= '0;
            reg_c  <= '0;
            reg_d  <= '0;
            reg_e  <= '0;
            reg_h  <= '0;
            reg_l  <= '0;
            reg_a  <= '0;
            reg_sp <= '0;
        end else if (wr_en) begin
            case (wr_sel)
                SEL_B:  reg_b <= wr_data[7:0];
                SEL_C:  reg_c <= wr_data[7:0];
                SEL_D:  reg_d <= wr_data[7:0];
                SEL_E:  reg_e <= wr_data[7:0];
                SEL_H:  reg_h <= wr_data[7:0];
                SEL_L:  reg_l <= wr_data[7:0];
                SEL_A:  reg_a <= wr_data[7:0];
                SEL_BC: {reg_b, reg_c} <= wr_data;
                SEL_DE: {reg_d, reg_e} <= wr_data;
                SEL_HL: {reg_h, reg_l} <= wr_data;
                SEL_SP: reg_sp <= wr_data;
                default: ;
            endcase
        end
    end

endmodule

/* hdl/exec_sequencer.sv */
module exec_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 insn_ready,
    input  z80_pkg::insn_t       insn,
    input  z80_pkg::insn_group_t group,
    input  z80_pkg::word_t       operand,
    input  z80_pkg::addr_t       fetch_addr,
    input  z80_pkg::byte_t       mem_data,
    input  z80_pkg::word_t       rd1_data,
    input  z80_pkg::word_t       rd2_data,
    output z80_pkg::reg_sel_t    rd1_sel,
    output z80_pkg::reg_sel_t    rd2_sel,
    output logic                 wr_en,
    output z80_pkg::reg_sel_t    wr_sel,
    output z80_pkg::word_t       wr_data,
    output z80_pkg::addr_t       addr,
    output logic                 read_mem,
    output logic                 write_mem,
    output z80_pkg::byte_t       write_data,
    output logic                 done,
    output logic                 insn_done
);
    import z80_pkg::*;

    logic [1:0] step;
    word_t      data_buf;

    logic [1:0] next_step;
    logic       next_done;
    addr_t      next_addr;
    logic       next_read;
    logic       next_write;
    byte_t      next_wdata;
    word_t      next_data;

    // Port 1 carries the address pair, port 2 the byte to store
    always_comb begin
        rd1_sel = SEL_HL;
        rd2_sel = SEL_A;
        case (group)
            GRP_LD_R_R:        rd1_sel = sel_reg8(insn[2:0]);
            GRP_LD_A_IND_BCDE,
            GRP_LD_IND_BCDE_A: rd1_sel = sel_pair(insn[5:4]);
            GRP_LD_IND_HL_R:   rd2_sel = sel_reg8(insn[2:0]);
            default: ;
        endcase
    end

    always_comb begin
        next_step  = step;
        next_done  = 1'b0;
        next_addr  = fetch_addr;
        next_read  = 1'b1;
        next_write = 1'b0;
        next_wdata = '0;
        next_data  = data_buf;
        wr_en      = 1'b0;
        wr_sel     = SEL_A;
        wr_data    = '0;

        if (insn_ready) begin
            next_step = step + 2'd1;
            case (group)
                GRP_LD_R_R: begin
                    wr_en     = 1'b1;
                    wr_sel    = sel_reg8(insn[5:3]);
                    wr_data   = rd1_data;
                    next_done = 1'b1;
                end
                GRP_LD_R_N: begin
                    wr_en     = 1'b1;
                    wr_sel    = sel_reg8(insn[5:3]);
                    wr_data   = word_t'(operand[7:0]);
                    next_done = 1'b1;
                end
                GRP_LD_DD_NN: begin
                    wr_en     = 1'b1;
                    wr_sel    = sel_pair(insn[5:4]);
                    wr_data   = operand;
                    next_done = 1'b1;
                end
                GRP_LD_A_IND_NN, GRP_LD_A_IND_BCDE: begin
                    if (step == 2'd0) begin
                        next_addr = (group == GRP_LD_A_IND_NN) ? operand : rd1_data;
                    end else begin
                        next_data[7:0] = mem_data;
                        wr_en          = 1'b1;
                        wr_sel         = SEL_A;
                        wr_data        = word_t'(next_data[7:0]);
                        next_done      = 1'b1;
                    end
                end
                GRP_LD_IND_NN_A, GRP_LD_IND_BCDE_A, GRP_LD_IND_HL_R, GRP_LD_IND_HL_N: begin
                    if (step == 2'd0) begin
                        next_addr  = (group == GRP_LD_IND_NN_A) ? operand : rd1_data;
                        next_read  = 1'b0;
                        next_write = 1'b1;
                        next_wdata = (group == GRP_LD_IND_HL_N) ? operand[7:0] : rd2_data[7:0];
                    end else begin
                        next_done = 1'b1;
                    end
                end
                GRP_LD_HL_IND_NN: begin
                    case (step)
                        2'd0: next_addr = operand;
                        2'd1: begin
                            next_data[7:0] = mem_data;
                            next_addr      = operand + 16'd1;
                        end
                        default: begin
                            next_data[15:8] = mem_data;
                            wr_en           = 1'b1;
                            wr_sel          = SEL_HL;
                            wr_data         = next_data;
                            next_done       = 1'b1;
                        end
                    endcase
                end
                GRP_LD_IND_NN_HL: begin
                    // Low byte at nn, high byte at nn+1
                    if (step == 2'd2) begin
                        next_done = 1'b1;
                    end else begin
                        next_addr  = (step == 2'd0) ? operand : operand + 16'd1;
                        next_read  = 1'b0;
                        next_write = 1'b1;
                        next_wdata = (step == 2'd0) ? rd1_data[7:0] : rd1_data[15:8];
                    end
                end
                default: next_done = 1'b1;
            endcase
        end

        if (next_done) begin
            next_step = '0;
            next_data = '0;
        end
    end

    assign insn_done = next_done;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step      <= '0;
            done      <= 1'b0;
            addr      <= '0;
            read_mem  <= 1'b1;
            write_mem <= 1'b0;
        end else begin
            step      <= next_step;
            done      <= next_done;
            addr      <= next_addr;
            read_mem  <= next_read;
            write_mem <= next_write;
        end
    end

    always_ff @(posedge clk) begin
        data_buf   <= next_data;
        write_data <= next_wdata;
    end

endmodule

/* hdl/z80_core.sv */
module z80_core (
    input  logic           clk,
    input  logic           reset,
    input  z80_pkg::byte_t mem_data,
    output z80_pkg::addr_t addr,
    output logic           read_mem,
    output logic           write_mem,
    output z80_pkg::byte_t write_data,
    output logic           done
);
    import z80_pkg::*;

    addr_t       fetch_addr;
    insn_t       insn;
    insn_group_t group;
    word_t       operand;
    logic        insn_ready;
    logic        insn_done;

    reg_sel_t    rd1_sel;
    reg_sel_t    rd2_sel;
    reg_sel_t    wr_sel;
    word_t       rd1_data;
    word_t       rd2_data;
    word_t       wr_data;
    logic        wr_en;

    // Length is consumed inside the collector only
    insn_collector collector (
        .clk        (clk),
        .reset      (reset),
        .mem_data   (mem_data),
        .insn_done  (insn_done),
        .fetch_addr (fetch_addr),
        .insn       (insn),
        .insn_len   (),
        .group      (group),
        .operand    (operand),
        .insn_ready (insn_ready)
    );

    register_file regs (
        .clk      (clk),
        .reset    (reset),
        .rd1_sel  (rd1_sel),
        .rd1_data (rd1_data),
        .rd2_sel  (rd2_sel),
        .rd2_data (rd2_data),
        .wr_en    (wr_en),
        .wr_sel   (wr_sel),
        .wr_data  (wr_data)
    );

    exec_sequencer sequencer (
        .clk        (clk),
        .reset      (reset),
        .insn_ready (insn_ready),
        .insn       (insn),
        .group      (group),
        .operand    (operand),
        .fetch_addr (fetch_addr),
        .mem_data   (mem_data),
        .rd1_data   (rd1_data),
        .rd2_data   (rd2_data),
        .rd1_sel    (rd1_sel),
        .rd2_sel    (rd2_sel),
        .wr_en      (wr_en),
        .wr_sel     (wr_sel),
        .wr_data    (wr_data),
        .addr       (addr),
        .read_mem   (read_mem),
        .write_mem  (write_mem),
        .write_data (write_data),
        .done       (done),
        .insn_done  (insn_done)
    );

endmodule

/* verification/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* verification/z80_core_tb.sv */
`include "z80_defs.svh"

module z80_core_tb;
    import z80_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 8;
    localparam int PAD_BYTES       = 4;
    localparam int CYCLES_PER_INSN = 8;
    localparam int SETUP_CYCLES    = 40;
    localparam int NUM_TESTS       = 6;
    localparam int TOTAL_INSNS     = 4 + 4 + 5 + 2 + 6 + 4;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * SETUP_CYCLES
                                     + TOTAL_INSNS * CYCLES_PER_INSN;

    localparam pair_t PAIR_BC = 2'd0;
    localparam pair_t PAIR_DE = 2'd1;
    localparam pair_t PAIR_HL = 2'd2;

    logic  clk;
    logic  gen_reset;
    logic  test_reset;
    logic  reset;
    byte_t mem_data;
    addr_t addr;
    logic  read_mem;
    logic  write_mem;
    byte_t write_data;
    logic  done;

    logic  load_en;
    addr_t load_addr;
    byte_t load_data;
    byte_t mem [0:(1 << `Z80_ADDR_W) - 1];

    byte_t       prog [$];
    addr_t       data_addr [$];
    byte_t       data_val [$];
    logic [31:0] lfsr_state;
    int          failures;

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) clock_gen (
        .clk   (clk),
        .reset (gen_reset)
    );

    assign reset = gen_reset | test_reset;

    z80_core UUT (
        .clk        (clk),
        .reset      (reset),
        .mem_data   (mem_data),
        .addr       (addr),
        .read_mem   (read_mem),
        .write_mem  (write_mem),
        .write_data (write_data),
        .done       (done)
    );

    // Memory answers in the same cycle, stores at the edge
    assign mem_data = mem[addr];

    always @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (write_mem) begin
            mem[addr] <= write_data;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    function automatic byte_t random_byte();
        byte_t value;
        int    i;
        value = '0;
        for (i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[6:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Z80 opcode encodings
    function automatic byte_t op_ld_r_n(input reg8_t dst);
        return {2'b00, dst, 3'b110};
    endfunction

    function automatic byte_t op_ld_r_r(input reg8_t dst, input reg8_t src);
        return {2'b01, dst, src};
    endfunction

    function automatic byte_t op_ld_hl_r(input reg8_t src);
        return {2'b01, 3'b110, src};
    endfunction

    function automatic byte_t op_ld_dd_nn(input pair_t dd);
        return {2'b00, dd, 4'b0001};
    endfunction

    task automatic check_value(input string test_name, input string what,
                               input logic [15:0] expected, input logic [15:0] actual);
        if (actual !== expected) begin
            failures++;
            $display("ERROR %s: %s expected %h actual %h", test_name, what, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    function automatic void preload(input addr_t a, input byte_t value);
        data_addr.push_back(a);
        data_val.push_back(value);
    endfunction

    task automatic load_byte(input addr_t a, input byte_t value);
        @(posedge clk);
        load_en   <= 1'b1;
        load_addr <= a;
        load_data <= value;
    endtask

    // Core held in reset while the program and its data are written
    task automatic launch_program();
        int i;
        @(posedge clk);
        test_reset <= 1'b1;
        repeat (PAD_BYTES) prog.push_back(8'h00);
        for (i = 0; i < prog.size(); i++) begin
            load_byte(addr_t'(i), prog[i]);
        end
        for (i = 0; i < data_addr.size(); i++) begin
            load_byte(data_addr[i], data_val[i]);
        end
        @(posedge clk);
        load_en <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        test_reset <= 1'b0;
        @(negedge clk);
        data_addr.delete();
        data_val.delete();
    endtask

    task automatic run_until_done(input string test_name, input int insn_count,
                                  output int writes);
        int seen;
        seen   = 0;
        writes = 0;
        while (seen < insn_count) begin
            @(negedge clk);
            check_value(test_name, "read and write together", 16'd0,
                        16'(read_mem & write_mem));
            if (done) seen++;
            if (write_mem) writes++;
        end
    endtask

    task automatic test_nop_sequence();
        string name;
        int    writes;
        name = "nop_sequence";
        prog = {8'h00, 8'h00, 8'h00, 8'h00};
        launch_program();
        check_value(name, "first fetch address", 16'h0000, addr);
        check_value(name, "read_mem after reset", 16'd1, 16'(read_mem));
        check_value(name, "write_mem after reset", 16'd0, 16'(write_mem));
        check_value(name, "done after reset", 16'd0, 16'(done));
        run_until_done(name, 4, writes);
        check_value(name, "write strobes", 16'd0, 16'(writes));
    endtask

    task automatic test_immediate_store();
        string name;
        int    writes;
        byte_t value;
        name  = "immediate_store";
        value = random_byte();
        prog  = {op_ld_r_n(`Z80_REG_B), value,
                 op_ld_r_r(`Z80_REG_D, `Z80_REG_B),
                 op_ld_r_r(`Z80_REG_A, `Z80_REG_D),
                 `Z80_OP_LD_IND_NN_A, 8'h00, 8'h40};
        preload(16'h4000, ~value);
        launch_program();
        run_until_done(name, 4, writes);
        check_value(name, "write strobes", 16'd1, 16'(writes));
        check_value(name, "byte at 4000", 16'(value), 16'(mem[16'h4000]));
    endtask

    task automatic test_hl_store();
        string name;
        int    writes;
        byte_t reg_value;
        byte_t imm_value;
        name      = "hl_store";
        reg_value = random_byte();
        imm_value = random_byte();
        prog = {op_ld_dd_nn(PAIR_HL), 8'h00, 8'h50,
                op_ld_r_n(`Z80_REG_E), reg_value,
                op_ld_hl_r(`Z80_REG_E),
                op_ld_dd_nn(PAIR_HL), 8'h23, 8'h51,
                `Z80_OP_LD_IND_HL_N, imm_value};
        preload(16'h5000, ~reg_value);
        preload(16'h5123, ~imm_value);
        launch_program();
        run_until_done(name, 5, writes);
        check_value(name, "write strobes", 16'd2, 16'(writes));
        check_value(name, "LD (HL),E byte", 16'(reg_value), 16'(mem[16'h5000]));
        check_value(name, "LD (HL),n byte", 16'(imm_value), 16'(mem[16'h5123]));
    endtask

    task automatic test_word_copy();
        string name;
        int    writes;
        byte_t low;
        byte_t high;
        name = "word_copy";
        low  = random_byte();
        high = random_byte();
        prog = {`Z80_OP_LD_HL_IND_NN, 8'h00, 8'h60,
                `Z80_OP_LD_IND_NN_HL, 8'h00, 8'h70};
        preload(16'h6000, low);
        preload(16'h6001, high);
        preload(16'h7000, ~low);
        preload(16'h7001, ~high);
        launch_program();
        run_until_done(name, 2, writes);
        check_value(name, "write strobes", 16'd2, 16'(writes));
        check_value(name, "low byte at 7000", 16'(low), 16'(mem[16'h7000]));
        check_value(name, "high byte at 7001", 16'(high), 16'(mem[16'h7001]));
    endtask

    task automatic test_byte_copy();
        string name;
        int    writes;
        byte_t via_pair;
        byte_t via_abs;
        name     = "byte_copy";
        via_pair = random_byte();
        via_abs  = random_byte();
        prog = {op_ld_dd_nn(PAIR_BC), 8'h00, 8'h61,
                op_ld_dd_nn(PAIR_DE), 8'h00, 8'h71,
                `Z80_OP_LD_A_IND_BC, `Z80_OP_LD_IND_DE_A,
                `Z80_OP_LD_A_IND_NN, 8'h80, 8'h61,
                `Z80_OP_LD_IND_NN_A, 8'h80, 8'h71};
        preload(16'h6100, via_pair);
        preload(16'h7100, ~via_pair);
        preload(16'h6180, via_abs);
        preload(16'h7180, ~via_abs);
        launch_program();
        run_until_done(name, 6, writes);
        check_value(name, "write strobes", 16'd2, 16'(writes));
        check_value(name, "copy through BC/DE", 16'(via_pair), 16'(mem[16'h7100]));
        check_value(name, "copy through nn", 16'(via_abs), 16'(mem[16'h7180]));
    endtask

    task automatic test_unknown_opcode();
        string name;
        int    writes;
        byte_t value;
        name  = "unknown_opcode";
        value = random_byte();
        // HALT and INC B are outside the kept set
        prog  = {8'h76, 8'h04,
                 op_ld_r_n(`Z80_REG_A), value,
                 `Z80_OP_LD_IND_NN_A, 8'h00, 8'h72};
        preload(16'h7200, ~value);
        launch_program();
        // Each unknown opcode is one byte long
        run_until_done(name, 1, writes);
        check_value(name, "fetch address after 76", 16'h0001, addr);
        check_value(name, "writes by 76", 16'd0, 16'(writes));
        run_until_done(name, 1, writes);
        check_value(name, "fetch address after 04", 16'h0002, addr);
        check_value(name, "writes by 04", 16'd0, 16'(writes));
        run_until_done(name, 2, writes);
        check_value(name, "write strobes after", 16'd1, 16'(writes));
        check_value(name, "byte at 7200", 16'(value), 16'(mem[16'h7200]));
    endtask

    initial begin
        test_reset = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        failures   = 0;
        lfsr_state = 32'h427501ba;
        test_nop_sequence();
        test_immediate_store();
        test_hl_store();
        test_word_copy();
        test_byte_copy();
        test_unknown_opcode();
        if (failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $fatal(1);
    end

endmodule

/* vlog.f */
+incdir+common
common/z80_pkg.sv
fetch/insn_decoder.sv
fetch/insn_collector.sv
hdl/register_file.sv
hdl/exec_sequencer.sv
hdl/z80_core.sv
verification/tb_clock_gen.sv
verification/z80_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= z80_core_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= All tests passed!

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@rm -f $(LOG)
	-$(SIM) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
